// ==== Bender.yml ====
package:
  name: csr_read_unit

sources:
  # RTL, package first
  - target: any(rtl, test)
    files:
      - verilog/csr_pkg.sv
      - verilog/csr_addr_decode.sv
      - verilog/csr_mreg_read.sv
      - verilog/hpm_slot.sv
      - verilog/csr_rd_merge.sv
      - verilog/csr_read_unit.sv

  # testbench, top module csr_read_unit_tb
  - target: test
    include_dirs:
      - verification
    files:
      - verification/csr_read_unit_tb.sv

// ==== project.f ====
+incdir+verification
verilog/csr_pkg.sv
verilog/csr_addr_decode.sv
verilog/csr_mreg_read.sv
verilog/hpm_slot.sv
verilog/csr_rd_merge.sv
verilog/csr_read_unit.sv
verification/csr_read_unit_tb.sv

// ==== verification/csr_read_tests.svh ====
// --------------------
// csr read tests
// reference model of the read port and the directed and random test sequences
// --------------------
`ifndef CSR_READ_TESTS_SVH
`define CSR_READ_TESTS_SVH

   // machine registers, machine counters, IDs
   logic [11:0] fixed_addrs [0:20] = '{12'h300, 12'h301, 12'h305, 12'h306, 12'h320,
      12'h340, 12'h341, 12'h342, 12'h343, 12'hB00, 12'hB02, 12'hB80, 12'hB82,
      12'hF11, 12'hF12, 12'hF13, 12'hF14, 12'h300, 12'h341, 12'hB80, 12'hF14};
   // cycle, time, instret and their high halves
   logic [11:0] shadow_addrs [0:5] = '{12'hC00, 12'hC01, 12'hC02, 12'hC80, 12'hC81, 12'hC82};
   // counter 0 of mhpmcounter, mhpmcounterh, hpmcounter, hpmcounterh, mhpmevent
   logic [11:0] hpm_bases [0:4] = '{12'hB00, 12'hB80, 12'hC00, 12'hC80, 12'h320};
   // supervisor, user trap, interrupt, PMP and debug space
   logic [11:0] dropped_addrs [0:15] = '{12'h100, 12'h105, 12'h106, 12'h140, 12'h141,
      12'h180, 12'h000, 12'h005, 12'h041, 12'h302, 12'h304, 12'h344, 12'h3A0,
      12'h3B0, 12'h7A0, 12'h7B1};

   // --------------------
   // expected {avail, data} for one read
   function automatic logic [32:0] csr_expect(input logic [11:0] addr, input logic [1:0] md);
      logic [4:0]  num;
      logic        perm;
      logic        ok;
      logic [31:0] val;
      int          k;
      num  = addr[4:0];
      // counter access: machine always, user by mcounteren bit, modes 1 and 2 never
      perm = (md == 2'b11) | ((md == 2'b00) & mcounteren[num]);
      ok   = 1'b1;
      val  = '0;
      case (addr)
         12'h300: val = mstatus;
         12'h301: val = misa;
         12'h305: val = mtvec;
         12'h306: val = mcounteren;
         12'h320: val = mcountinhibit;
         12'h340: val = mscratch;
         // epc is instruction aligned
         12'h341: val = mepc & (IALIGN16 ? ~32'h1 : ~32'h3);
         12'h342: val = mcause;
         12'h343: val = mtval;
         12'hB00: val = mcycle[31:0];
         12'hB80: val = mcycle[63:32];
         12'hB02: val = minstret[31:0];
         12'hB82: val = minstret[63:32];
         12'hC00: {ok, val} = {perm, mcycle[31:0]};
         12'hC80: {ok, val} = {perm, mcycle[63:32]};
         12'hC01: {ok, val} = {perm, mtime[31:0]};
         12'hC81: {ok, val} = {perm, mtime[63:32]};
         12'hC02: {ok, val} = {perm, minstret[31:0]};
         12'hC82: {ok, val} = {perm, minstret[63:32]};
         12'hF11: val = MVENDORID;
         12'hF12: val = MARCHID;
         12'hF13: val = MIMPID;
         12'hF14: val = MHARTID;
         default:
         begin
            ok = 1'b0;
            // counters 3 up to the last implemented one
            if (num >= 5'd3 && num < NUM_MHPM + 3)
            begin
               k = num - 3;
               case (addr[11:5])
                  7'h58: {ok, val} = {1'b1, mhpmcounter[k][31:0]};
                  7'h5C: {ok, val} = {1'b1, mhpmcounter[k][63:32]};
                  7'h60: {ok, val} = {perm, mhpmcounter[k][31:0]};
                  7'h64: {ok, val} = {perm, mhpmcounter[k][63:32]};
                  7'h19: {ok, val} = {1'b1, mhpmevent[k]};
                  default: ok = 1'b0;
               endcase
            end
         end
      endcase
      // denied or unmapped reads give zero data too
      return ok ? {1'b1, val} : 33'h0;
   endfunction

   // --------------------
   // register inputs
   task automatic load_regs();
      begin
         mtime         = {$urandom, $urandom};
         mstatus       = $urandom;
         misa          = $urandom;
         mtvec         = $urandom;
         mcounteren    = $urandom;
         mcountinhibit = $urandom;
         mscratch      = $urandom;
         mepc          = $urandom;
         mcause        = $urandom;
         mtval         = $urandom;
         mcycle        = {$urandom, $urandom};
         minstret      = {$urandom, $urandom};
         for (int i = 0; i < NUM_MHPM; i++)
         begin
            mhpmcounter[i] = {$urandom, $urandom};
            mhpmevent[i]   = $urandom;
         end
      end
   endtask

   // one idle cycle so that no read in flight sees the new values
   task automatic new_regs();
      begin
         @(negedge clk_in);
         pend_valid = 1'b0;
         load_regs();
      end
   endtask

   // --------------------
   // tests
   task automatic check_after_reset();
      begin
         start_test("reset");
         repeat (5) @(posedge clk_in);
         @(negedge clk_in);
         check_value("reset outputs", 33'h0, {csr_rd_avail, csr_rd_data});
         rst_n = 1'b1;
         end_test();
      end
   endtask

   task automatic fixed_register_reads();
      begin
         start_test("fixed");
         new_regs();
         // low bits set so the alignment clear is visible
         mepc = mepc | 32'h3;
         for (int i = 0; i < 21; i++)
            read_csr(fixed_addrs[i], 2'b11);
         end_test();
      end
   endtask

   task automatic shadow_gating();
      begin
         start_test("shadow");
         for (int md = 0; md < 4; md++)
            for (int pass = 0; pass < 2; pass++)
            begin
               new_regs();
               // complementary enables, each counter seen allowed and denied
               mcounteren = (pass == 0) ? 32'h0000_0005 : 32'h0000_0002;
               for (int i = 0; i < 6; i++)
                  read_csr(shadow_addrs[i], 2'(md));
            end
         end_test();
      end
   endtask

   task automatic hpm_bank_sweep();
      begin
         start_test("hpm");
         new_regs();
         for (int n = 3; n < 32; n++)
            for (int g = 0; g < 5; g++)
               read_csr(hpm_bases[g] | 12'(n), 2'($urandom % 4));
         end_test();
      end
   endtask

   task automatic dropped_addresses();
      logic [11:0] a;
      logic [32:0] r;
      int          found;
      begin
         start_test("dropped");
         for (int i = 0; i < 16; i++)
            read_csr(dropped_addrs[i], 2'($urandom % 4));
         found = 0;
         // random addresses that no mode may read
         while (found < 20)
         begin
            a = 12'($urandom);
            r = csr_expect(a, 2'b11);
            if (!r[32])
            begin
               read_csr(a, 2'($urandom % 4));
               found++;
            end
         end
         end_test();
      end
   endtask

   task automatic random_back_to_back();
      logic [11:0] a;
      begin
         start_test("random");
         for (int i = 0; i < RAND_READS; i++)
         begin
            if (i % 100 == 0)
               new_regs();
            case ($urandom % 4)
               0:       a = fixed_addrs[$urandom % 21];
               1:       a = hpm_bases[$urandom % 5] | 12'($urandom % 32);
               2:       a = shadow_addrs[$urandom % 6];
               default: a = 12'($urandom);
            endcase
            read_csr(a, 2'($urandom % 4));
         end
         end_test();
      end
   endtask

`endif

// ==== verification/csr_read_unit_tb.sv ====
// --------------------
// csr read unit testbench
// random register values, directed and random reads, each checked one clock later
// --------------------
`timescale 1ns/1ps

module csr_read_unit_tb;

   localparam int          NUM_MHPM  = 4;
   localparam bit          IALIGN16  = 1'b0;
   localparam logic [31:0] MVENDORID = 32'h0000_0612;
   localparam logic [31:0] MARCHID   = 32'h0000_0023;
   localparam logic [31:0] MIMPID    = 32'h0001_0400;
   localparam logic [31:0] MHARTID   = 32'h0000_0002;

   // run length, roughly one cycle per read plus idle cycles between tests
   localparam int RAND_READS      = 600;
   localparam int DIRECTED_CYCLES = 300;
   localparam int TIMEOUT_CYCLES  = 2 * (RAND_READS + DIRECTED_CYCLES) + 200;

   logic                             clk_in = 1'b0;
   logic                             rst_n;
   logic [11:0]                      csr_rd_addr;
   logic [1:0]                       mode;
   logic [63:0]                      mtime;
   logic [31:0]                      mstatus;
   logic [31:0]                      misa;
   logic [31:0]                      mtvec;
   logic [31:0]                      mcounteren;
   logic [31:0]                      mcountinhibit;
   logic [31:0]                      mscratch;
   logic [31:0]                      mepc;
   logic [31:0]                      mcause;
   logic [31:0]                      mtval;
   logic [63:0]                      mcycle;
   logic [63:0]                      minstret;
   logic [NUM_MHPM-1:0][63:0]        mhpmcounter;
   logic [NUM_MHPM-1:0][31:0]        mhpmevent;
   logic                             csr_rd_avail;
   logic [31:0]                      csr_rd_data;

   // expected result of the read just driven, then one stage later for the compare
   logic        pend_valid = 1'b0;
   logic [32:0] pend_exp   = '0;
   string       pend_name  = "";
   logic        chk_valid  = 1'b0;
   logic [32:0] chk_exp    = '0;
   string       chk_name   = "";

   int    cycle_count = 0;
   int    chk_count   = 0;
   int    err_count   = 0;
   int    test_count  = 0;
   int    test_chk0;
   int    test_err0;
   string test_name   = "";

   csr_read_unit #(
      .NUM_MHPM  (NUM_MHPM),
      .IALIGN16  (IALIGN16),
      .MVENDORID (MVENDORID),
      .MARCHID   (MARCHID),
      .MIMPID    (MIMPID),
      .MHARTID   (MHARTID)
   ) dut0 (
      .clk_in        (clk_in),
      .rst_n         (rst_n),
      .csr_rd_addr   (csr_rd_addr),
      .mode          (mode),
      .mtime         (mtime),
      .mstatus       (mstatus),
      .misa          (misa),
      .mtvec         (mtvec),
      .mcounteren    (mcounteren),
      .mcountinhibit (mcountinhibit),
      .mscratch      (mscratch),
      .mepc          (mepc),
      .mcause        (mcause),
      .mtval         (mtval),
      .mcycle        (mcycle),
      .minstret      (minstret),
      .mhpmcounter   (mhpmcounter),
      .mhpmevent     (mhpmevent),
      .csr_rd_avail  (csr_rd_avail),
      .csr_rd_data   (csr_rd_data)
   );

   // 4 ns clock
   always #2 clk_in = ~clk_in;

   // --------------------
   // compare of {avail, data} against the reference
   task automatic check_value(input string name, input logic [32:0] expected,
                              input logic [32:0] actual);
      begin
         chk_count++;
         if (actual !== expected)
         begin
            err_count++;
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
         end
      end
   endtask

   // drive side works on the falling edge, DUT registers on the rising edge
   always @(posedge clk_in)
   begin
      chk_valid <= pend_valid;
      chk_exp   <= pend_exp;
      chk_name  <= pend_name;
   end

   // outputs settled half a cycle after the register stage
   always @(negedge clk_in)
   begin
      if (chk_valid)
         check_value(chk_name, chk_exp, {csr_rd_avail, csr_rd_data});
   end

   // hang guard
   always @(posedge clk_in)
   begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         $display("ERROR: simulation hung, stopped after %0d cycles", cycle_count);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   // --------------------
   // read sequencing
   task automatic read_csr(input logic [11:0] addr, input logic [1:0] md);
      begin
         @(negedge clk_in);
         csr_rd_addr = addr;
         mode        = md;
         pend_exp    = csr_expect(addr, md);
         pend_name   = $sformatf("%s addr %03h mode %0d", test_name, addr, md);
         pend_valid  = 1'b1;
      end
   endtask

   // idle until the last read in flight has been compared
   task automatic drain_pipe();
      begin
         @(negedge clk_in);
         pend_valid = 1'b0;
         @(posedge clk_in);
         @(negedge clk_in);
      end
   endtask

   task automatic start_test(input string name);
      begin
         test_name = name;
         test_chk0 = chk_count;
         test_err0 = err_count;
      end
   endtask

   task automatic end_test();
      begin
         drain_pipe();
         test_count++;
         $display("test %-8s done: %0d checks, %0d errors", test_name,
                  chk_count - test_chk0, err_count - test_err0);
      end
   endtask

   `include "csr_read_tests.svh"

   // --------------------
   // main sequence
   initial
   begin
      void'($urandom(70));
      rst_n       = 1'b0;
      csr_rd_addr = 12'h300;
      mode        = 2'b11;
      load_regs();
      check_after_reset();
      fixed_register_reads();
      shadow_gating();
      hpm_bank_sweep();
      dropped_addresses();
      random_back_to_back();
      $display("summary: %0d tests, %0d checks, %0d errors", test_count, chk_count,
               err_count);
      if (err_count == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

// ==== verilog/csr_addr_decode.sv ====
// --------------------
// csr address decoder
// sorts the address into register groups and checks counter access
// --------------------
`timescale 1ns/1ps

module csr_addr_decode
   import csr_pkg::*;
(
   input  csr_addr_u        csr_rd_addr,
   input  logic [1:0]       mode,
   input  logic [RSZ-1:0]   mcounteren,
   output logic             fixed_sel,
   output logic             hpm_m_lo,
   output logic             hpm_m_hi,
   output logic             hpm_u_lo,
   output logic             hpm_u_hi,
   output logic             hpm_evt,
   output logic [4:0]       cntr_num,
   output logic             cntr_en
);

   // group, half and pad bits taken together
   logic [6:0] grp;
   // counters 0..2 are the fixed cycle, time and instret
   logic       in_bank;
   logic       any_hpm;
   logic       user_ro;

   // --------------------
   // counter view
   assign grp      = {csr_rd_addr.cv.group, csr_rd_addr.cv.hi, csr_rd_addr.cv.pad};
   assign in_bank  = (csr_rd_addr.cv.num >= 5'd3);
   assign cntr_num = csr_rd_addr.cv.num;

   assign hpm_m_lo = in_bank & (grp == CSR_MHPMCOUNTER_BASE[11:5]);
   assign hpm_m_hi = in_bank & (grp == CSR_MHPMCOUNTERH_BASE[11:5]);
   assign hpm_u_lo = in_bank & (grp == CSR_HPMCOUNTER_BASE[11:5]);
   assign hpm_u_hi = in_bank & (grp == CSR_HPMCOUNTERH_BASE[11:5]);
   assign hpm_evt  = in_bank & (grp == CSR_MHPMEVENT_BASE[11:5]);

   assign any_hpm  = hpm_m_lo | hpm_m_hi | hpm_u_lo | hpm_u_hi | hpm_evt;

   // --------------------
   // privilege view
   // the fixed block only owns machine level space and the user read-only counters
   assign user_ro   = (csr_rd_addr.pv.access == 2'b11) & (csr_rd_addr.pv.priv == U_MODE);
   assign fixed_sel = ~any_hpm & ((csr_rd_addr.pv.priv == M_MODE) | user_ro);

   // counter access permission
   // no supervisor here, modes 1 and 2 never see a counter
   always_comb
   begin
      case (mode)
         M_MODE:  cntr_en = 1'b1;
         U_MODE:  cntr_en = mcounteren[cntr_num];
         default: cntr_en = 1'b0;
      endcase
   end

endmodule

// ==== verilog/csr_mreg_read.sv ====
// --------------------
// fixed csr read block
// machine trap registers, IDs and the base counters with their user shadows
// --------------------
`timescale 1ns/1ps

module csr_mreg_read
   import csr_pkg::*;
#(
   parameter bit             IALIGN16  = 1'b0,
   parameter logic [RSZ-1:0] MVENDORID = '0,
   parameter logic [RSZ-1:0] MARCHID   = '0,
   parameter logic [RSZ-1:0] MIMPID    = '0,
   parameter logic [RSZ-1:0] MHARTID   = '0
)
(
   input  csr_addr_u          csr_rd_addr,
   input  logic               fixed_sel,
   input  logic               cntr_en,
   input  logic [2*RSZ-1:0]   mtime,
   input  logic [RSZ-1:0]     mstatus,
   input  logic [RSZ-1:0]     misa,
   input  logic [RSZ-1:0]     mtvec,
   input  logic [RSZ-1:0]     mcounteren,
   input  logic [RSZ-1:0]     mcountinhibit,
   input  logic [RSZ-1:0]     mscratch,
   input  logic [RSZ-1:0]     mepc,
   input  logic [RSZ-1:0]     mcause,
   input  logic [RSZ-1:0]     mtval,
   input  logic [2*RSZ-1:0]   mcycle,
   input  logic [2*RSZ-1:0]   minstret,
   output logic               hit,
   output logic [RSZ-1:0]     data
);

   // pc alignment mask for mepc
   localparam logic [RSZ-1:0] EPC_MASK = IALIGN16 ? ~32'h1 : ~32'h3;

   logic           known;
   logic           shadow;
   logic [RSZ-1:0] rd_val;

   // --------------------
   // address match
   always_comb
   begin
      known  = 1'b1;
      rd_val = '0;
      case (csr_rd_addr)
         // trap setup and handling
         CSR_MSTATUS:       rd_val = mstatus;
         CSR_MISA:          rd_val = misa;
         CSR_MTVEC:         rd_val = mtvec;
         CSR_MCOUNTEREN:    rd_val = mcounteren;
         CSR_MCOUNTINHIBIT: rd_val = mcountinhibit;
         CSR_MSCRATCH:      rd_val = mscratch;
         CSR_MEPC:          rd_val = mepc & EPC_MASK;
         CSR_MCAUSE:        rd_val = mcause;
         CSR_MTVAL:         rd_val = mtval;
         // machine counters
         CSR_MCYCLE:        rd_val = mcycle[RSZ-1:0];
         CSR_MCYCLEH:       rd_val = mcycle[2*RSZ-1:RSZ];
         CSR_MINSTRET:      rd_val = minstret[RSZ-1:0];
         CSR_MINSTRETH:     rd_val = minstret[2*RSZ-1:RSZ];
         // user shadows of the same counters plus time
         CSR_CYCLE:         rd_val = mcycle[RSZ-1:0];
         CSR_CYCLEH:        rd_val = mcycle[2*RSZ-1:RSZ];
         CSR_TIME:          rd_val = mtime[RSZ-1:0];
         CSR_TIMEH:         rd_val = mtime[2*RSZ-1:RSZ];
         CSR_INSTRET:       rd_val = minstret[RSZ-1:0];
         CSR_INSTRETH:      rd_val = minstret[2*RSZ-1:RSZ];
         // information, read only constants
         CSR_MVENDORID:     rd_val = MVENDORID;
         CSR_MARCHID:       rd_val = MARCHID;
         CSR_MIMPID:        rd_val = MIMPID;
         CSR_MHARTID:       rd_val = MHARTID;
         default:           known  = 1'b0;
      endcase
   end

   // --------------------
   // access gate
   // among the fixed addresses only the user shadows sit at privilege level 0
   assign shadow = (csr_rd_addr.pv.priv == U_MODE);

   assign hit  = fixed_sel & known & (cntr_en | ~shadow);
   // a denied high half returns zero as well
   assign data = hit ? rd_val : '0;

endmodule

// ==== verilog/csr_pkg.sv ====
// --------------------
// csr package
// register width, privilege codes, CSR addresses and the address union
// --------------------
package csr_pkg;

   localparam int RSZ = 32;

   // privilege codes, also the encoding of address bits 9:8
   localparam logic [1:0] M_MODE = 2'b11;
   localparam logic [1:0] U_MODE = 2'b00;

   // --------------------
   // machine trap and status
   localparam logic [11:0] CSR_MSTATUS       = 12'h300;
   localparam logic [11:0] CSR_MISA          = 12'h301;
   localparam logic [11:0] CSR_MTVEC         = 12'h305;
   localparam logic [11:0] CSR_MCOUNTEREN    = 12'h306;
   localparam logic [11:0] CSR_MCOUNTINHIBIT = 12'h320;
   localparam logic [11:0] CSR_MSCRATCH      = 12'h340;
   localparam logic [11:0] CSR_MEPC          = 12'h341;
   localparam logic [11:0] CSR_MCAUSE        = 12'h342;
   localparam logic [11:0] CSR_MTVAL         = 12'h343;

   // machine counters
   localparam logic [11:0] CSR_MCYCLE        = 12'hB00;
   localparam logic [11:0] CSR_MINSTRET      = 12'hB02;
   localparam logic [11:0] CSR_MCYCLEH       = 12'hB80;
   localparam logic [11:0] CSR_MINSTRETH     = 12'hB82;

   // user counter shadows, read only
   localparam logic [11:0] CSR_CYCLE         = 12'hC00;
   localparam logic [11:0] CSR_TIME          = 12'hC01;
   localparam logic [11:0] CSR_INSTRET       = 12'hC02;
   localparam logic [11:0] CSR_CYCLEH        = 12'hC80;
   localparam logic [11:0] CSR_TIMEH         = 12'hC81;
   localparam logic [11:0] CSR_INSTRETH      = 12'hC82;

   // information registers
   localparam logic [11:0] CSR_MVENDORID     = 12'hF11;
   localparam logic [11:0] CSR_MARCHID       = 12'hF12;
   localparam logic [11:0] CSR_MIMPID        = 12'hF13;
   localparam logic [11:0] CSR_MHARTID       = 12'hF14;

   // --------------------
   // performance counter groups, address of counter 3 in each
   localparam logic [11:0] CSR_MHPMCOUNTER_BASE  = 12'hB03;
   localparam logic [11:0] CSR_MHPMCOUNTERH_BASE = 12'hB83;
   localparam logic [11:0] CSR_HPMCOUNTER_BASE   = 12'hC03;
   localparam logic [11:0] CSR_HPMCOUNTERH_BASE  = 12'hC83;
   localparam logic [11:0] CSR_MHPMEVENT_BASE    = 12'h323;

   // one address word, two ways of reading it
   typedef union packed {
      struct packed {
         logic [1:0] access;   // 2'b11 = read only
         logic [1:0] priv;     // lowest privilege that owns it
         logic [7:0] index;
      } pv;
      struct packed {
         logic [3:0] group;
         logic       hi;       // upper half of a 64-bit counter
         logic [1:0] pad;      // 2'b01 marks the event selectors
         logic [4:0] num;      // counter number 0..31
      } cv;
   } csr_addr_u;

endpackage

// ==== verilog/csr_rd_merge.sv ====
// --------------------
// csr read merge
// ORs all source hits and data, one register stage to the outputs
// --------------------
`timescale 1ns/1ps

module csr_rd_merge
   import csr_pkg::*;
#(
   parameter int NUM_MHPM = 4
)
(
   input  logic                          clk_in,
   input  logic                          rst_n,
   input  logic                          fix_hit,
   input  logic [RSZ-1:0]                fix_data,
   input  logic [NUM_MHPM-1:0]           slot_hit,
   input  logic [NUM_MHPM-1:0][RSZ-1:0]  slot_data,
   output logic                          csr_rd_avail,
   output logic [RSZ-1:0]                csr_rd_data
);

   logic           any_hit;
   logic [RSZ-1:0] or_data;

   // masked OR, only the claiming source contributes
   always_comb
   begin
      any_hit = fix_hit;
      or_data = fix_data & {RSZ{fix_hit}};
      for (int i = 0; i < NUM_MHPM; i++)
      begin
         any_hit = any_hit | slot_hit[i];
         or_data = or_data | (slot_data[i] & {RSZ{slot_hit[i]}});
      end
   end

   // --------------------
   // output stage
   always_ff @(posedge clk_in)
   begin
      if (!rst_n)
      begin
         csr_rd_avail <= 1'b0;
         csr_rd_data  <= '0;
      end
      else
      begin
         csr_rd_avail <= any_hit;
         csr_rd_data  <= or_data;
      end
   end

   // fixed block and slots decode independently, never two owners
   a_one_source: assert property (@(posedge clk_in) disable iff (!rst_n)
                                  $onehot0({fix_hit, slot_hit}))
      else $error("csr merge: more than one source claimed the address");

endmodule

// ==== verilog/csr_read_unit.sv ====
// --------------------
// csr read unit
// top of the CSR read port, address and mode in, data one clock later
// --------------------
`timescale 1ns/1ps

module csr_read_unit
   import csr_pkg::*;
#(
   parameter int             NUM_MHPM  = 4,
   parameter bit             IALIGN16  = 1'b0,
   parameter logic [RSZ-1:0] MVENDORID = '0,
   parameter logic [RSZ-1:0] MARCHID   = '0,
   parameter logic [RSZ-1:0] MIMPID    = '0,
   parameter logic [RSZ-1:0] MHARTID   = '0
)
(
   input  logic                            clk_in,
   input  logic                            rst_n,
   input  csr_addr_u                       csr_rd_addr,
   input  logic [1:0]                      mode,
   input  logic [2*RSZ-1:0]                mtime,
   input  logic [RSZ-1:0]                  mstatus,
   input  logic [RSZ-1:0]                  misa,
   input  logic [RSZ-1:0]                  mtvec,
   input  logic [RSZ-1:0]                  mcounteren,
   input  logic [RSZ-1:0]                  mcountinhibit,
   input  logic [RSZ-1:0]                  mscratch,
   input  logic [RSZ-1:0]                  mepc,
   input  logic [RSZ-1:0]                  mcause,
   input  logic [RSZ-1:0]                  mtval,
   input  logic [2*RSZ-1:0]                mcycle,
   input  logic [2*RSZ-1:0]                minstret,
   input  logic [NUM_MHPM-1:0][2*RSZ-1:0]  mhpmcounter,
   input  logic [NUM_MHPM-1:0][RSZ-1:0]    mhpmevent,
   output logic                            csr_rd_avail,
   output logic [RSZ-1:0]                  csr_rd_data
);

   // decoder outputs
   logic       fixed_sel;
   logic       hpm_m_lo;
   logic       hpm_m_hi;
   logic       hpm_u_lo;
   logic       hpm_u_hi;
   logic       hpm_evt;
   logic [4:0] cntr_num;
   logic       cntr_en;

   // source returns
   logic                          fix_hit;
   logic [RSZ-1:0]                fix_data;
   logic [NUM_MHPM-1:0]           slot_hit;
   logic [NUM_MHPM-1:0][RSZ-1:0]  slot_data;

   csr_addr_decode u_decode (
      .csr_rd_addr (csr_rd_addr),
      .mode        (mode),
      .mcounteren  (mcounteren),
      .fixed_sel   (fixed_sel),
      .hpm_m_lo    (hpm_m_lo),
      .hpm_m_hi    (hpm_m_hi),
      .hpm_u_lo    (hpm_u_lo),
      .hpm_u_hi    (hpm_u_hi),
      .hpm_evt     (hpm_evt),
      .cntr_num    (cntr_num),
      .cntr_en     (cntr_en)
   );

   csr_mreg_read #(
      .IALIGN16  (IALIGN16),
      .MVENDORID (MVENDORID),
      .MARCHID   (MARCHID),
      .MIMPID    (MIMPID),
      .MHARTID   (MHARTID)
   ) u_mreg (
      .csr_rd_addr   (csr_rd_addr),
      .fixed_sel     (fixed_sel),
      .cntr_en       (cntr_en),
      .mtime         (mtime),
      .mstatus       (mstatus),
      .misa          (misa),
      .mtvec         (mtvec),
      .mcounteren    (mcounteren),
      .mcountinhibit (mcountinhibit),
      .mscratch      (mscratch),
      .mepc          (mepc),
      .mcause        (mcause),
      .mtval         (mtval),
      .mcycle        (mcycle),
      .minstret      (minstret),
      .hit           (fix_hit),
      .data          (fix_data)
   );

   // --------------------
   // one slot per performance counter
   for (genvar g = 0; g < NUM_MHPM; g++)
   begin : g_slot
      hpm_slot #(
         .SLOT (g)
      ) u_slot (
         .hpm_m_lo  (hpm_m_lo),
         .hpm_m_hi  (hpm_m_hi),
         .hpm_u_lo  (hpm_u_lo),
         .hpm_u_hi  (hpm_u_hi),
         .hpm_evt   (hpm_evt),
         .cntr_num  (cntr_num),
         .cntr_en   (cntr_en),
         .counter   (mhpmcounter[g]),
         .event_sel (mhpmevent[g]),
         .hit       (slot_hit[g]),
         .data      (slot_data[g])
      );
   end

   csr_rd_merge #(
      .NUM_MHPM (NUM_MHPM)
   ) u_merge (
      .clk_in       (clk_in),
      .rst_n        (rst_n),
      .fix_hit      (fix_hit),
      .fix_data     (fix_data),
      .slot_hit     (slot_hit),
      .slot_data    (slot_data),
      .csr_rd_avail (csr_rd_avail),
      .csr_rd_data  (csr_rd_data)
   );

endmodule

// ==== verilog/hpm_slot.sv ====
// --------------------
// performance counter slot
// answers for one counter, its user shadow and its event selector
// --------------------
`timescale 1ns/1ps

module hpm_slot
   import csr_pkg::*;
#(
   parameter int SLOT = 0
)
(
   input  logic               hpm_m_lo,
   input  logic               hpm_m_hi,
   input  logic               hpm_u_lo,
   input  logic               hpm_u_hi,
   input  logic               hpm_evt,
   input  logic [4:0]         cntr_num,
   input  logic               cntr_en,
   input  logic [2*RSZ-1:0]   counter,
   input  logic [RSZ-1:0]     event_sel,
   output logic               hit,
   output logic [RSZ-1:0]     data
);

   // slot 0 is counter 3
   localparam logic [4:0] MY_NUM = 5'(SLOT + 3);

   logic mine;
   logic want_hi;

   assign mine    = (cntr_num == MY_NUM);
   assign want_hi = hpm_m_hi | hpm_u_hi;

   // user halves also need the mcounteren permission
   assign hit = mine & (hpm_m_lo | hpm_m_hi | hpm_evt | ((hpm_u_lo | hpm_u_hi) & cntr_en));

   always_comb
   begin
      if (hpm_evt)
         data = event_sel;
      else if (want_hi)
         data = counter[2*RSZ-1:RSZ];
      else
         data = counter[RSZ-1:0];
   end

   // the decoder must hand over exactly one group for a claimed address
   a_hit_group: assert final (!hit || $onehot({hpm_m_lo, hpm_m_hi, hpm_u_lo, hpm_u_hi, hpm_evt}))
      else $error("hpm slot %0d: hit without a single group flag", SLOT);

endmodule
